//--- Makefile
sim:
	verilator --binary --timing --assert --timescale 1ns/1ps --top-module fetch_tb \
	  -f fetch_top.f -o fetch_sim
	./obj_dir/fetch_sim

clean:
	rm -rf obj_dir

.PHONY: sim clean

//--- common/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

  localparam int unsigned mem_words = 64;
  localparam int unsigned mem_aw = $clog2(mem_words);

  // apb register offsets
  localparam logic [11:0] csr_ctrl = 12'h000;
  localparam logic [11:0] csr_boot = 12'h004;
  localparam logic [11:0] csr_wait = 12'h008;
  localparam logic [11:0] csr_count = 12'h00C;
  localparam logic [11:0] mem_window = 12'h100;  // write only program window

  // rv32 major opcodes
  localparam logic [6:0] op_jal = 7'b1101111;
  localparam logic [6:0] op_jalr = 7'b1100111;
  localparam logic [6:0] op_branch = 7'b1100011;
  localparam logic [6:0] op_system = 7'b1110011;

  typedef struct packed {
    logic [11:0] imm12;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_type_t;

  // same word, seen raw or as i-type fields
  typedef union packed {
    logic [31:0] raw;
    i_type_t     i_view;
  } instr_u;

  typedef struct packed {
    logic        valid;
    logic [31:0] pc;
    instr_u      instr;
  } fetch_pkt_t;

  typedef struct packed {
    logic        valid;
    logic [31:0] target;
  } redirect_t;

  typedef struct packed {
    logic              valid;
    logic [mem_aw-1:0] addr;
  } mem_req_t;

  typedef struct packed {
    logic        ready;
    logic [31:0] data;
  } mem_rsp_t;

  typedef struct packed {
    logic        enable;
    logic [31:0] boot_pc;
    logic [1:0]  wait_states;
  } fetch_cfg_t;

  typedef struct packed {
    logic              valid;
    logic [mem_aw-1:0] addr;
    logic [31:0]       data;
  } mem_wr_t;

endpackage

`default_nettype wire

//--- design/fetch_csr.sv
`default_nettype none

module fetch_csr (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  psel_i,
  input  logic                  penable_i,
  input  logic                  pwrite_i,
  input  logic [11:0]           paddr_i,
  input  logic [31:0]           pwdata_i,
  input  logic                  retire_i,
  output logic [31:0]           prdata_o,
  output logic                  pready_o,
  output logic                  pslverr_o,
  output fetch_pkg::fetch_cfg_t cfg_o,
  output fetch_pkg::mem_wr_t    mem_wr_o
);
  import fetch_pkg::*;

  fetch_cfg_t        cfg_q;
  logic [31:0]       count_q;
  logic              wr_valid_q;
  logic [mem_aw-1:0] wr_addr_q;
  logic [31:0]       wr_data_q;
  logic              access;
  logic              wr_en;
  logic              in_window;
  logic              mapped;

  assign access = psel_i & penable_i;
  assign wr_en = access & pwrite_i;
  assign in_window = paddr_i[11:mem_aw+2] == mem_window[11:mem_aw+2];
  assign pready_o = 1'b1;          // no wait states on apb
  assign pslverr_o = access & ~mapped;

  always_comb begin
    mapped = 1'b1;
    prdata_o = 32'd0;
    case (paddr_i)
      csr_ctrl: prdata_o = {31'd0, cfg_q.enable};
      csr_boot: prdata_o = cfg_q.boot_pc;
      csr_wait: prdata_o = {30'd0, cfg_q.wait_states};
      csr_count: prdata_o = count_q;
      default: mapped = in_window;  // window reads back zero
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      cfg_q <= '0;
      count_q <= 32'd0;
      wr_valid_q <= 1'b0;
    end else begin
      wr_valid_q <= wr_en & in_window;
      if (wr_en && paddr_i == csr_count) begin
        count_q <= 32'd0;            // any write clears
      end else if (retire_i) begin
        count_q <= count_q + 32'd1;
      end
      if (wr_en) begin
        case (paddr_i)
          csr_ctrl: cfg_q.enable <= pwdata_i[0];
          csr_boot: cfg_q.boot_pc <= pwdata_i;
          csr_wait: cfg_q.wait_states <= pwdata_i[1:0];
          default: cfg_q <= cfg_q;
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en && in_window) begin
      wr_addr_q <= paddr_i[mem_aw+1:2];
      wr_data_q <= pwdata_i;
    end
  end

  assign cfg_o = cfg_q;
  assign mem_wr_o = '{valid: wr_valid_q, addr: wr_addr_q, data: wr_data_q};

  a_apb_penable: assert property (@(posedge clk) disable iff (rst)
    penable_i |-> psel_i);

endmodule

`default_nettype wire

//--- design/fetch_top.sv
`default_nettype none

module fetch_top (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  psel_i,
  input  logic                  penable_i,
  input  logic                  pwrite_i,
  input  logic [11:0]           paddr_i,
  input  logic [31:0]           pwdata_i,
  output logic [31:0]           prdata_o,
  output logic                  pready_o,
  output logic                  pslverr_o,
  input  logic                  stall_i,
  input  fetch_pkg::redirect_t  redirect_i,
  output fetch_pkg::fetch_pkt_t pkt_o
);
  import fetch_pkg::*;

  fetch_cfg_t cfg;
  mem_wr_t    mem_wr;
  mem_req_t   mem_req;
  mem_rsp_t   mem_rsp;
  logic       retire;

  fetch_csr u_csr (
    .clk       (clk),
    .rst       (rst),
    .psel_i    (psel_i),
    .penable_i (penable_i),
    .pwrite_i  (pwrite_i),
    .paddr_i   (paddr_i),
    .pwdata_i  (pwdata_i),
    .retire_i  (retire),
    .prdata_o  (prdata_o),
    .pready_o  (pready_o),
    .pslverr_o (pslverr_o),
    .cfg_o     (cfg),
    .mem_wr_o  (mem_wr)
  );

  fetch_unit u_fetch (
    .clk        (clk),
    .rst        (rst),
    .cfg_i      (cfg),
    .mem_rsp_i  (mem_rsp),
    .stall_i    (stall_i),
    .redirect_i (redirect_i),
    .mem_req_o  (mem_req),
    .pkt_o      (pkt_o),
    .retire_o   (retire)
  );

  instr_mem u_mem (
    .clk           (clk),
    .rst           (rst),
    .wait_states_i (cfg.wait_states),
    .req_i         (mem_req),
    .wr_i          (mem_wr),
    .rsp_o         (mem_rsp)
  );

endmodule

`default_nettype wire

//--- dv/fetch_cases.txt
# cmd a b, all hex: W addr wdata | R addr expected | E pc instr
# J target now (1 drives at once, 0 after the stop) | S max_stall_cycles unused
R 00c 00000000
W 100 00100093
W 104 00200113
W 108 002081b3
W 10c 0100006f
W 11c 00208463
W 120 00400213
W 124 00000073
W 140 00500293
W 144 30002373
W 148 00100073
W 000 00000001
E 000 00100093
J 080 1
E 004 00200113
E 008 002081b3
E 00c 0100006f
R 00c 00000004
W 00c 00000000
W 008 00000003
R 008 00000003
S 3 0
J 01c 0
E 01c 00208463
J 020 0
E 020 00400213
E 024 00000073
R 010 00000000
J 040 0
E 040 00500293
E 044 30002373
E 048 00100073
R 00c 00000006
W 000 00000000
W 004 00000040
R 004 00000040
W 000 00000001
E 040 00500293
W 000 00000000
E 044 30002373
R 000 00000000
R 00c 00000008
W 008 00000000
W 000 00000001
E 040 00500293
E 044 30002373
E 048 00100073

//--- dv/fetch_tb.sv
`default_nettype none

module fetch_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import fetch_pkg::*;

  logic             clk;
  logic             rst;
  logic             psel_i;
  logic             penable_i;
  logic             pwrite_i;
  logic [11:0]      paddr_i;
  logic [31:0]      pwdata_i;
  logic [31:0]      prdata_o;
  logic             pready_o;
  logic             pslverr_o;
  logic             stall_i;
  redirect_t        redirect_i;
  fetch_pkt_t       pkt;

  integer           seed;
  int               stall_max;    // longest random stall per packet
  int               stall_left;
  int               accepted_cnt;
  int               e_cnt;
  int               fd;
  int               code;
  logic [7:0]       cmd;
  logic [31:0]      arg_a;
  logic [31:0]      arg_b;
  logic [31:0]      rdata;
  logic [8*120-1:0] skip_line;
  logic             done;
  fetch_pkt_t       got;

  fetch_top dut (
    .clk       (clk),
    .rst       (rst),
    .psel_i    (psel_i),
    .penable_i (penable_i),
    .pwrite_i  (pwrite_i),
    .paddr_i   (paddr_i),
    .pwdata_i  (pwdata_i),
    .prdata_o  (prdata_o),
    .pready_o  (pready_o),
    .pslverr_o (pslverr_o),
    .stall_i   (stall_i),
    .redirect_i(redirect_i),
    .pkt_o     (pkt)
  );

  task automatic check(input string name, input logic [64:0] got_v,
                       input logic [64:0] exp_v);
    if (got_v !== exp_v) begin
      $display("mismatch at %0d ns: %s = %0h, expected %0h", $time, name, got_v, exp_v);
      $display("Errors found");
      $fatal(1);
    end
  endtask

  // offsets outside ctrl, boot, wait, count and the program window
  function automatic logic offset_unmapped(input logic [11:0] addr);
    return !(addr == 12'h000 || addr == 12'h004 || addr == 12'h008 || addr == 12'h00c ||
             (addr >= 12'h100 && addr <= 12'h1ff));
  endfunction

  task automatic apb_xfer(input logic wr, input logic [11:0] addr,
                          input logic [31:0] wdata, output logic [31:0] rd);
    @(posedge clk);
    psel_i <= 1'b1;             // setup phase
    penable_i <= 1'b0;
    pwrite_i <= wr;
    paddr_i <= addr;
    pwdata_i <= wdata;
    @(posedge clk);
    penable_i <= 1'b1;
    @(posedge clk);
    check("pready_o", 65'(pready_o), 65'd1);  // every access completes at once
    rd = prdata_o;
    check("pslverr_o", 65'(pslverr_o), 65'(offset_unmapped(addr)));
    psel_i <= 1'b0;
    penable_i <= 1'b0;
  endtask

  task automatic wait_accept(output fetch_pkt_t p);
    @(posedge clk);
    while (!(pkt.valid && !stall_i)) @(posedge clk);
    p = pkt;
  endtask

  task automatic drive_redirect(input logic [31:0] target, input logic now);
    if (!now) begin
      repeat (4) begin
        @(posedge clk);
        check("pkt_o.valid", 65'(pkt.valid), 65'd0);  // parked after control flow
      end
    end
    @(posedge clk);
    redirect_i <= '{valid: 1'b1, target: target};
    @(posedge clk);
    redirect_i.valid <= 1'b0;
  endtask

  initial begin : clock_gen
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  initial begin : stall_gen
    seed = 74;
    stall_left = 0;
    stall_i <= 1'b0;
    forever begin
      @(posedge clk);
      if (pkt.valid && !stall_i) begin
        stall_left = int'($unsigned($random(seed)) % (stall_max + 1));  // next packet
      end else if (pkt.valid && stall_left > 0) begin
        stall_left = stall_left - 1;
      end
      stall_i <= (stall_left > 0);
    end
  end

  initial begin : monitor
    fetch_pkt_t held_pkt;
    logic       held;
    held = 1'b0;
    accepted_cnt = 0;
    forever begin
      @(posedge clk);
      if (held) check("pkt_o under stall", pkt, held_pkt);
      if (pkt.valid && !stall_i) accepted_cnt++;
      held = pkt.valid && stall_i;
      held_pkt = pkt;
    end
  end

  initial begin : watchdog
    int               wfd;
    int               lines;
    logic [8*120-1:0] line;
    lines = 0;
    wfd = $fopen("dv/fetch_cases.txt", "r");
    if (wfd != 0) begin
      while ($fgets(line, wfd) != 0) lines++;
      $fclose(wfd);
    end
    repeat (60 * lines + 20) @(posedge clk);  // some slack for reset
    $display("fetch did not complete in time");
    $display("Errors found");
    $fatal(1);
  end

  initial begin : main
    rst <= 1'b1;
    psel_i <= 1'b0;
    penable_i <= 1'b0;
    pwrite_i <= 1'b0;
    paddr_i <= 12'd0;
    pwdata_i <= 32'd0;
    redirect_i <= '0;
    stall_max = 0;
    e_cnt = 0;
    done = 1'b0;
    fd = $fopen("dv/fetch_cases.txt", "r");
    if (fd == 0) begin
      $display("cannot open dv/fetch_cases.txt");
      $display("Errors found");
      $fatal(1);
    end
    repeat (5) @(posedge clk);
    rst <= 1'b0;
    while (!done) begin
      code = $fscanf(fd, " %c", cmd);
      if (code != 1) begin
        done = 1'b1;
      end else if (cmd == "#") begin
        code = $fgets(skip_line, fd);  // column notes
      end else begin
        code = $fscanf(fd, " %h %h", arg_a, arg_b);
        if (code != 2) begin
          $display("malformed line in cases file");
          $display("Errors found");
          $fatal(1);
        end
        case (cmd)
          "W": apb_xfer(1'b1, arg_a[11:0], arg_b, rdata);
          "R": begin
            apb_xfer(1'b0, arg_a[11:0], 32'd0, rdata);
            check("prdata_o", 65'(rdata), 65'(arg_b));
          end
          "E": begin
            wait_accept(got);
            check("pkt_o.pc", 65'(got.pc), 65'(arg_a));
            check("pkt_o.instr", 65'(got.instr), 65'(arg_b));
            e_cnt++;
          end
          "J": drive_redirect(arg_a, arg_b[0]);
          "S": begin
            @(negedge clk);
            stall_max = int'(arg_a);
          end
          default: begin
            $display("unknown command %c in cases file", cmd);
            $display("Errors found");
            $fatal(1);
          end
        endcase
      end
    end
    $fclose(fd);
    repeat (10) @(posedge clk);
    check("accepted packets", 65'(accepted_cnt), 65'(e_cnt));  // none lost or extra
    $display("No errors");
    $finish;
  end

endmodule

`default_nettype wire

//--- fetch/fetch_unit.sv
`default_nettype none

module fetch_unit (
  input  logic                  clk,
  input  logic                  rst,
  input  fetch_pkg::fetch_cfg_t cfg_i,
  input  fetch_pkg::mem_rsp_t   mem_rsp_i,
  input  logic                  stall_i,
  input  fetch_pkg::redirect_t  redirect_i,
  output fetch_pkg::mem_req_t   mem_req_o,
  output fetch_pkg::fetch_pkt_t pkt_o,
  output logic                  retire_o
);
  import fetch_pkg::*;

  typedef enum logic [1:0] {
    st_idle,
    st_request,
    st_hold,
    st_wait_redirect
  } state_t;

  state_t            state_q;
  logic              req_valid_q;
  logic [mem_aw-1:0] req_addr_q;
  logic [31:0]       req_pc_q;     // pc of the word in flight
  logic              pkt_valid_q;
  logic [31:0]       pkt_pc_q;
  instr_u            pkt_instr_q;
  logic              en_q;
  logic              restart_q;    // enable rose, boot pc not yet fetched
  logic              en_rise;
  logic              restart;
  logic              accept;
  logic              is_ctrl;
  logic [31:0]       seq_pc;
  logic              launch;
  logic [31:0]       launch_pc;

  assign en_rise = cfg_i.enable & ~en_q;
  assign restart = en_rise | restart_q;
  assign accept = pkt_valid_q & ~stall_i;
  assign seq_pc = pkt_pc_q + 32'd4;
  assign retire_o = accept;

  // jal/jalr/branch by opcode, ecall/ebreak by imm12
  always_comb begin
    is_ctrl = 1'b0;
    if (pkt_instr_q.raw[6:0] == op_jal || pkt_instr_q.raw[6:0] == op_jalr ||
        pkt_instr_q.raw[6:0] == op_branch) begin
      is_ctrl = 1'b1;
    end else if (pkt_instr_q.i_view.opcode == op_system &&
                 pkt_instr_q.i_view.imm12[11:1] == 11'd0) begin
      is_ctrl = 1'b1;
    end
  end

  // when and where the next request goes out
  always_comb begin
    launch = 1'b0;
    launch_pc = seq_pc;
    if (cfg_i.enable) begin
      case (state_q)
        st_idle: begin
          launch = restart;
          launch_pc = cfg_i.boot_pc;
        end
        st_hold: begin
          launch = accept & (restart | ~is_ctrl);
          launch_pc = restart ? cfg_i.boot_pc : seq_pc;
        end
        st_wait_redirect: begin
          launch = restart | redirect_i.valid;
          launch_pc = restart ? cfg_i.boot_pc : redirect_i.target;
        end
        default: launch = 1'b0;  // request in flight
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= st_idle;
      req_valid_q <= 1'b0;
      pkt_valid_q <= 1'b0;
      en_q <= 1'b0;
      restart_q <= 1'b0;
    end else begin
      en_q <= cfg_i.enable;
      if (launch) begin
        restart_q <= 1'b0;
      end else if (en_rise) begin
        restart_q <= 1'b1;
      end
      case (state_q)
        st_idle: begin
          if (launch) state_q <= st_request;
        end
        st_request: begin
          if (mem_rsp_i.ready) begin
            req_valid_q <= 1'b0;
            pkt_valid_q <= 1'b1;
            state_q <= st_hold;
          end
        end
        st_hold: begin
          if (accept) begin
            pkt_valid_q <= 1'b0;
            if (launch) begin
              state_q <= st_request;
            end else if (cfg_i.enable && is_ctrl) begin
              state_q <= st_wait_redirect;  // park until execute resolves it
            end else begin
              state_q <= st_idle;
            end
          end
        end
        default: begin
          if (launch) begin
            state_q <= st_request;
          end else if (!cfg_i.enable) begin
            state_q <= st_idle;
          end
        end
      endcase
      if (launch) req_valid_q <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (launch) begin
      req_addr_q <= launch_pc[mem_aw+1:2];
      req_pc_q <= launch_pc;
    end
    if (state_q == st_request && mem_rsp_i.ready) begin
      pkt_pc_q <= req_pc_q;
      pkt_instr_q <= mem_rsp_i.data;
    end
  end

  assign mem_req_o = '{valid: req_valid_q, addr: req_addr_q};
  assign pkt_o = '{valid: pkt_valid_q, pc: pkt_pc_q, instr: pkt_instr_q};

  a_req_stable: assert property (@(posedge clk) disable iff (rst)
    mem_req_o.valid && !mem_rsp_i.ready |=> $stable(mem_req_o.addr));

  a_pkt_hold: assert property (@(posedge clk) disable iff (rst)
    pkt_o.valid && stall_i |=> $stable(pkt_o));

endmodule

`default_nettype wire

//--- fetch/instr_mem.sv
`default_nettype none

module instr_mem (
  input  logic                clk,
  input  logic                rst,
  input  logic [1:0]          wait_states_i,
  input  fetch_pkg::mem_req_t req_i,
  input  fetch_pkg::mem_wr_t  wr_i,
  output fetch_pkg::mem_rsp_t rsp_o
);
  import fetch_pkg::*;

  logic [31:0] mem_q [mem_words];
  logic        busy_q;
  logic [1:0]  cnt_q;      // wait cycles left
  logic        ready_q;
  logic [31:0] data_q;
  logic        new_req;
  logic        fire;       // ready goes out next cycle

  // a request still high on its ready cycle is the old one
  assign new_req = req_i.valid & ~busy_q & ~ready_q;
  assign fire = (new_req && wait_states_i == 2'd0) || (busy_q && cnt_q == 2'd1);

  always_ff @(posedge clk) begin
    if (wr_i.valid) mem_q[wr_i.addr] <= wr_i.data;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      busy_q <= 1'b0;
      cnt_q <= 2'd0;
      ready_q <= 1'b0;
    end else begin
      ready_q <= fire;
      if (new_req && wait_states_i != 2'd0) begin
        busy_q <= 1'b1;
        cnt_q <= wait_states_i;
      end else if (busy_q) begin
        cnt_q <= cnt_q - 2'd1;
        if (cnt_q == 2'd1) busy_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (fire) data_q <= mem_q[req_i.addr];
  end

  assign rsp_o = '{ready: ready_q, data: data_q};

  a_no_stray_ready: assert property (@(posedge clk) disable iff (rst)
    $rose(rsp_o.ready) |-> req_i.valid);

endmodule

`default_nettype wire

//--- fetch_top.f
common/fetch_pkg.sv
fetch/instr_mem.sv
fetch/fetch_unit.sv
design/fetch_csr.sv
design/fetch_top.sv
dv/fetch_tb.sv
